//--- Bender.yml
package:
  name: rv32i_core

export_include_dirs:
  - src

sources:
  - files:
      - src/core_pkg.sv
      - src/decoder.sv
      - src/regfile.sv
      - src/forwarding_unit.sv
      - src/alu.sv
      - src/datamem.sv
      - src/core.sv
  - target: test
    files:
      - tests/core_properties.sv
      - tests/core_tb.sv

//--- compile.f
+incdir+src
src/core_pkg.sv
src/decoder.sv
src/regfile.sv
src/forwarding_unit.sv
src/alu.sv
src/datamem.sv
src/core.sv
tests/core_properties.sv
tests/core_tb.sv

//--- src/alu.sv
`include "core_defines.svh"

module alu import core_pkg::*; (
	input  logic [`XLEN-1:0] op_a,
	input  logic [`XLEN-1:0] op_b,
	input  alu_op_e          alu_op,
	output logic [`XLEN-1:0] res,
	output logic             zero,
	output logic             less,
	output logic             less_u
);

	localparam int SHW = $clog2(`XLEN);

	logic [`XLEN:0]   diff; // Extra bit holds the borrow
	logic [SHW-1:0]   shamt;
	logic             sign_a, sign_b;

	assign diff   = {1'b0, op_a} - {1'b0, op_b};
	assign shamt  = op_b[SHW-1:0];
	assign sign_a = op_a[`XLEN-1];
	assign sign_b = op_b[`XLEN-1];

	// Branch flags, all from the one subtraction
	assign zero   = (diff[`XLEN-1:0] == '0);
	assign less_u = diff[`XLEN];
	assign less   = (sign_a ^ sign_b) ? sign_a : diff[`XLEN-1]; // Signs differ, negative one is less

	always_comb begin
		case (alu_op)
			ALU_ADD:    res = op_a + op_b;
			ALU_SUB:    res = diff[`XLEN-1:0];
			ALU_AND:    res = op_a & op_b;
			ALU_OR:     res = op_a | op_b;
			ALU_XOR:    res = op_a ^ op_b;
			ALU_SLT:    res = {{(`XLEN-1){1'b0}}, less};
			ALU_SLTU:   res = {{(`XLEN-1){1'b0}}, less_u};
			ALU_SLL:    res = op_a << shamt;
			ALU_SRL:    res = op_a >> shamt;
			ALU_SRA:    res = $signed(op_a) >>> shamt;
			ALU_PASS_B: res = op_b;
			default:    res = '0;
		endcase
	end

endmodule

//--- src/core.sv
`include "core_defines.svh"

module core import core_pkg::*; (
	input  logic              CLK,
	input  logic              rst_n,
	output logic [`PC_W-1:0]  imem_addr, // Fetch address
	input  logic [31:0]       imem_data, // Instruction at imem_addr, same cycle
	input  logic [`BE_W-1:0]  con_write,
	input  logic [`DM_AW-1:0] con_addr,
	input  logic [`XLEN-1:0]  con_in,
	output logic [`XLEN-1:0]  con_out
);

	if_id_t   if_id;
	id_exe_t  id_exe;
	exe_mem_t exe_mem;
	mem_wb_t  mem_wb;

	logic [`PC_W-1:0]  pc, pc4, pc_next;
	ctrl_t             id_ctrl;
	logic [`XLEN-1:0]  id_imm, rf_a, rf_b;
	logic [`XLEN-1:0]  rs1_val, rs2_val;  // Operands after forwarding
	logic [`RF_AW-1:0] id_rs_a, id_rs_b, id_rd;
	logic              use_a, use_b, load_stall, id_jump;
	fwd_src_e          src_a, src_b;
	logic [`PC_W-1:0]  br_base, br_sum, br_target;
	logic [`XLEN-1:0]  exe_res, exe_fwd, mem_fwd, wb_data, dm_rdata;
	logic              exe_zero, exe_less, exe_less_u, br_taken;

	function automatic logic [`XLEN-1:0] pc_ext(input logic [`PC_W-1:0] p);
		return {{(`XLEN-`PC_W){1'b0}}, p};
	endfunction

	// Result of a stage as WB would write it
	function automatic logic [`XLEN-1:0] stage_val(input wb_sel_e sel,
			input logic [`XLEN-1:0] alu_v, input logic [`XLEN-1:0] load_v,
			input logic [`PC_W-1:0] p4);
		case (sel)
			WB_LOAD: return load_v;
			WB_PC4:  return pc_ext(p4);
			default: return alu_v;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] fwd_pick(input fwd_src_e src,
			input logic [`XLEN-1:0] rf_v, input logic [`XLEN-1:0] exe_v,
			input logic [`XLEN-1:0] mem_v, input logic [`XLEN-1:0] wb_v);
		case (src)
			FWD_EXE: return exe_v;
			FWD_MEM: return mem_v;
			FWD_WB:  return wb_v;
			default: return rf_v;
		endcase
	endfunction

	// IF
	assign imem_addr = pc;
	assign pc4       = pc + `PC_W'(4);

	// Taken branch first, then stall, then ID jump
	always_comb begin
		if (br_taken) pc_next = id_exe.branch_target;
		else if (load_stall) pc_next = pc;
		else if (id_jump) pc_next = br_target;
		else pc_next = pc4;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) pc <= `RESET_PC;
		else pc <= pc_next;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0; // Zero word decodes as bubble
		end else if (br_taken || (id_jump && !load_stall)) begin
			if_id <= '0; // Wrong-path fetch
		end else if (!load_stall) begin
			if_id <= '{pc: pc, pc4: pc4, inst: imem_data};
		end
	end

	// ID
	assign id_rs_a = if_id.inst[19:15];
	assign id_rs_b = if_id.inst[24:20];
	assign id_rd   = if_id.inst[11:7];
	assign id_jump = id_ctrl.is_jal || id_ctrl.is_jalr;

	// LUI and JAL read nothing, I-type reads only rs1
	assign use_a = (id_ctrl.wr_en || id_ctrl.dm_we || id_ctrl.is_branch)
	               && id_ctrl.alu_op != ALU_PASS_B && !id_ctrl.is_jal;
	assign use_b = id_ctrl.dm_we || id_ctrl.is_branch
	               || (id_ctrl.wr_en && !id_ctrl.sel_imm_b && id_ctrl.wb_sel == WB_ALU);

	decoder i_decoder (.inst(if_id.inst), .ctrl(id_ctrl), .imm(id_imm));

	regfile i_regfile (
		.CLK(CLK), .rst_n(rst_n),
		.wr_en(mem_wb.ctrl.wr_en), .wr_addr(mem_wb.rd), .wr_data(wb_data),
		.rs_a(id_rs_a), .rs_b(id_rs_b), .rd_a(rf_a), .rd_b(rf_b)
	);

	forwarding_unit i_forwarding_unit (
		.rs_a(id_rs_a), .rs_b(id_rs_b), .use_a(use_a), .use_b(use_b),
		.exe_rd(id_exe.rd), .exe_ctrl(id_exe.ctrl),
		.mem_rd(exe_mem.rd), .mem_ctrl(exe_mem.ctrl),
		.wb_rd(mem_wb.rd), .wb_ctrl(mem_wb.ctrl),
		.src_a(src_a), .src_b(src_b), .load_stall(load_stall)
	);

	assign rs1_val = fwd_pick(src_a, rf_a, exe_fwd, mem_fwd, wb_data);
	assign rs2_val = fwd_pick(src_b, rf_b, exe_fwd, mem_fwd, wb_data);

	// Target adder, PC based for branch and JAL, rs1 based for JALR
	assign br_base   = id_ctrl.sel_pc_a ? if_id.pc : rs1_val[`PC_W-1:0];
	assign br_sum    = br_base + id_imm[`PC_W-1:0];
	assign br_target = {br_sum[`PC_W-1:1], br_sum[0] & ~id_ctrl.is_jalr};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			id_exe <= '0;
		end else if (br_taken || load_stall) begin
			id_exe <= '0;
		end else begin
			id_exe <= '{
				ctrl:          id_ctrl,
				pc4:           if_id.pc4,
				op_a:          rs1_val,
				op_b:          id_ctrl.sel_imm_b ? id_imm : rs2_val,
				store_data:    rs2_val,
				branch_target: br_target,
				rd:            id_rd
			};
		end
	end

	// EXE
	alu i_alu (
		.op_a(id_exe.op_a), .op_b(id_exe.op_b), .alu_op(id_exe.ctrl.alu_op),
		.res(exe_res), .zero(exe_zero), .less(exe_less), .less_u(exe_less_u)
	);

	assign exe_fwd = (id_exe.ctrl.wb_sel == WB_PC4) ? pc_ext(id_exe.pc4) : exe_res;

	always_comb begin
		case (id_exe.ctrl.funct3)
			3'd0: br_taken = exe_zero;    // BEQ
			3'd1: br_taken = !exe_zero;   // BNE
			3'd4: br_taken = exe_less;    // BLT
			3'd5: br_taken = !exe_less;   // BGE
			3'd6: br_taken = exe_less_u;  // BLTU
			3'd7: br_taken = !exe_less_u; // BGEU
			default: br_taken = 1'b0;
		endcase
		br_taken = br_taken && id_exe.ctrl.is_branch;
	end

	// Store writes at the end of EXE, load data shows in MEM
	datamem i_datamem (
		.CLK(CLK),
		.we(id_exe.ctrl.dm_we), .addr(exe_res[`DM_AW+1:2]), .wdata(id_exe.store_data),
		.rdata(dm_rdata),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) exe_mem <= '0;
		else exe_mem <= '{ctrl: id_exe.ctrl, pc4: id_exe.pc4, alu_out: exe_res, rd: id_exe.rd};
	end

	// MEM
	assign mem_fwd = stage_val(exe_mem.ctrl.wb_sel, exe_mem.alu_out, dm_rdata, exe_mem.pc4);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= '{ctrl: exe_mem.ctrl, pc4: exe_mem.pc4, alu_out: exe_mem.alu_out,
				load_data: dm_rdata, rd: exe_mem.rd};
		end
	end

	// WB
	assign wb_data = stage_val(mem_wb.ctrl.wb_sel, mem_wb.alu_out, mem_wb.load_data, mem_wb.pc4);

endmodule

//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register width
`define XLEN 32

// Byte lanes per data word
`define BE_W (`XLEN / 8)

// Byte PC, enough for a 4 KiB program space
`define PC_W 12

`define RF_AW 5 // 32 architectural registers

// Data memory, word addressed
`define DM_AW 10
`define DM_WORDS (1 << `DM_AW)

// First fetch after reset
`define RESET_PC 12'h000

`endif

//--- src/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

	// RV32I major opcodes in the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_PASS_B // LUI
	} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

	// Where an ID operand comes from
	typedef enum logic [1:0] {FWD_RF, FWD_EXE, FWD_MEM, FWD_WB} fwd_src_e;

	// All zero is a bubble
	typedef struct packed {
		alu_op_e    alu_op;
		logic       sel_imm_b; // ALU B from immediate
		logic       sel_pc_a;  // Target adder based on PC, else on rs1
		logic       wr_en;     // Register write in WB
		logic       dm_we;     // Store
		logic       is_load;
		logic       is_branch;
		logic [2:0] funct3;    // Branch condition
		logic       is_jal;
		logic       is_jalr;
		wb_sel_e    wb_sel;
	} ctrl_t;

	typedef struct packed {
		logic [`PC_W-1:0] pc;
		logic [`PC_W-1:0] pc4;
		logic [31:0]      inst;
	} if_id_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [`PC_W-1:0]  pc4;
		logic [`XLEN-1:0]  op_a;
		logic [`XLEN-1:0]  op_b;
		logic [`XLEN-1:0]  store_data;
		logic [`PC_W-1:0]  branch_target; // Used only if the branch is taken
		logic [`RF_AW-1:0] rd;
	} id_exe_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [`PC_W-1:0]  pc4;
		logic [`XLEN-1:0]  alu_out;
		logic [`RF_AW-1:0] rd;
	} exe_mem_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [`PC_W-1:0]  pc4;
		logic [`XLEN-1:0]  alu_out;
		logic [`XLEN-1:0]  load_data;
		logic [`RF_AW-1:0] rd;
	} mem_wb_t;

endpackage

//--- src/datamem.sv
`include "core_defines.svh"

module datamem (
	input  logic              CLK,
	// Core side, driven from EXE
	input  logic              we,
	input  logic [`DM_AW-1:0] addr,
	input  logic [`XLEN-1:0]  wdata,
	output logic [`XLEN-1:0]  rdata,   // Valid in MEM
	// Protocol controller side
	input  logic [`BE_W-1:0]  con_write, // Byte mask
	input  logic [`DM_AW-1:0] con_addr,
	input  logic [`XLEN-1:0]  con_in,
	output logic [`XLEN-1:0]  con_out
);

	logic [`XLEN-1:0] mem [`DM_WORDS];
	logic             con_hit;

	// Both ports on one word, con side takes it
	assign con_hit = (|con_write) && (con_addr == addr);

	always_ff @(posedge CLK) begin
		if (we && !con_hit) begin
			mem[addr] <= wdata;
		end
		for (int i = 0; i < `BE_W; i++) begin
			if (con_write[i]) begin
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			end
		end
		rdata   <= mem[addr];     // Read before write
		con_out <= mem[con_addr];
	end

endmodule

//--- src/decoder.sv
`include "core_defines.svh"

module decoder import core_pkg::*; (
	input  logic [31:0]      inst,
	output ctrl_t            ctrl,
	output logic [`XLEN-1:0] imm
);

	opcode_e          opcode;
	logic [2:0]       funct3;
	logic             alt;   // funct7[5], SUB and SRA
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;

	// funct3 to ALU op, shared by OP and OP_IMM
	function automatic alu_op_e funct_op(input logic [2:0] f3, input logic sub_sra);
		alu_op_e op;
		case (f3)
			3'd0: op = sub_sra ? ALU_SUB : ALU_ADD;
			3'd1: op = ALU_SLL;
			3'd2: op = ALU_SLT;
			3'd3: op = ALU_SLTU;
			3'd4: op = ALU_XOR;
			3'd5: op = sub_sra ? ALU_SRA : ALU_SRL;
			3'd6: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign alt    = inst[30];

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0; // Bubble unless recognised
		imm  = '0;
		case (opcode)
			OPC_OP: begin
				ctrl.alu_op = funct_op(funct3, alt);
				ctrl.wr_en  = 1'b1;
			end
			OPC_OP_IMM: begin
				ctrl.alu_op    = funct_op(funct3, alt && funct3 == 3'd5); // Bit 30 only means SRAI
				ctrl.sel_imm_b = 1'b1;
				ctrl.wr_en     = 1'b1;
				imm            = imm_i;
			end
			OPC_LUI: begin
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.sel_imm_b = 1'b1;
				ctrl.wr_en     = 1'b1;
				imm            = imm_u;
			end
			OPC_LOAD: begin
				ctrl.sel_imm_b = 1'b1; // Address is rs1 + imm
				ctrl.wr_en     = 1'b1;
				ctrl.is_load   = 1'b1;
				ctrl.wb_sel    = WB_LOAD;
				imm            = imm_i;
			end
			OPC_STORE: begin
				ctrl.sel_imm_b = 1'b1;
				ctrl.dm_we     = 1'b1;
				imm            = imm_s;
			end
			OPC_BRANCH: begin
				ctrl.alu_op    = ALU_SUB; // Flags come from rs1 - rs2
				ctrl.sel_pc_a  = 1'b1;
				ctrl.is_branch = 1'b1;
				ctrl.funct3    = funct3;
				imm            = imm_b;
			end
			OPC_JAL: begin
				ctrl.sel_pc_a = 1'b1;
				ctrl.wr_en    = 1'b1;
				ctrl.is_jal   = 1'b1;
				ctrl.wb_sel   = WB_PC4; // Link
				imm           = imm_j;
			end
			OPC_JALR: begin
				ctrl.wr_en   = 1'b1;
				ctrl.is_jalr = 1'b1;
				ctrl.wb_sel  = WB_PC4;
				imm          = imm_i;
			end
			default: ;
		endcase
	end

endmodule

//--- src/forwarding_unit.sv
`include "core_defines.svh"

module forwarding_unit import core_pkg::*; (
	input  logic [`RF_AW-1:0] rs_a,
	input  logic [`RF_AW-1:0] rs_b,
	input  logic              use_a,
	input  logic              use_b,
	input  logic [`RF_AW-1:0] exe_rd,
	input  ctrl_t             exe_ctrl,
	input  logic [`RF_AW-1:0] mem_rd,
	input  ctrl_t             mem_ctrl,
	input  logic [`RF_AW-1:0] wb_rd,
	input  ctrl_t             wb_ctrl,
	output fwd_src_e          src_a,
	output fwd_src_e          src_b,
	output logic              load_stall
);

	logic exe_hit_a, exe_hit_b;
	logic mem_hit_a, mem_hit_b;
	logic wb_hit_a, wb_hit_b;

	// A live writer of the same register, x0 excluded
	function automatic logic hit(input logic [`RF_AW-1:0] rs, input logic use_r,
			input logic [`RF_AW-1:0] rd, input logic wr_en);
		return use_r && wr_en && rs != '0 && rs == rd;
	endfunction

	assign exe_hit_a = hit(rs_a, use_a, exe_rd, exe_ctrl.wr_en);
	assign exe_hit_b = hit(rs_b, use_b, exe_rd, exe_ctrl.wr_en);
	assign mem_hit_a = hit(rs_a, use_a, mem_rd, mem_ctrl.wr_en);
	assign mem_hit_b = hit(rs_b, use_b, mem_rd, mem_ctrl.wr_en);
	assign wb_hit_a  = hit(rs_a, use_a, wb_rd, wb_ctrl.wr_en);
	assign wb_hit_b  = hit(rs_b, use_b, wb_rd, wb_ctrl.wr_en);

	// Youngest writer wins
	// EXE load data does not exist yet
	assign src_a = (exe_hit_a && !exe_ctrl.is_load) ? FWD_EXE :
	               mem_hit_a ? FWD_MEM :
	               wb_hit_a  ? FWD_WB  : FWD_RF;

	assign src_b = (exe_hit_b && !exe_ctrl.is_load) ? FWD_EXE :
	               mem_hit_b ? FWD_MEM :
	               wb_hit_b  ? FWD_WB  : FWD_RF;

	// Load in EXE feeding ID, wait one cycle until it reaches MEM
	assign load_stall = exe_ctrl.is_load && (exe_hit_a || exe_hit_b);

endmodule

//--- src/regfile.sv
`include "core_defines.svh"

module regfile (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              wr_en,
	input  logic [`RF_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]  wr_data,
	input  logic [`RF_AW-1:0] rs_a,
	input  logic [`RF_AW-1:0] rs_b,
	output logic [`XLEN-1:0]  rd_a,
	output logic [`XLEN-1:0]  rd_b
);

	logic [`XLEN-1:0] regs [1 << `RF_AW];

	// Written by WB at the edge, x0 never written
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Old value on a same-cycle write, WB forwarding supplies the new one
	assign rd_a = (rs_a == '0) ? '0 : regs[rs_a];
	assign rd_b = (rs_b == '0) ? '0 : regs[rs_b];

endmodule

//--- tests/core_properties.sv
`include "core_defines.svh"

module core_properties (
	input logic             CLK,
	input logic             rst_n,
	input logic [`PC_W-1:0] imem_addr,
	input logic             load_stall,
	input logic             store_en   // Store in EXE, write at the next edge
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // Failed assertions so far

	// Fetch stays word aligned
	a_fetch_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
		imem_addr[1:0] == 2'b00)
		else begin
			$error("fetch address %h is not word aligned", imem_addr);
			fail_count++;
		end

	// PC frozen across a load-use bubble
	a_stall_holds_pc: assert property (@(posedge CLK) disable iff (!rst_n)
		load_stall |=> imem_addr == $past(imem_addr))
		else begin
			$error("fetch address moved during a load stall");
			fail_count++;
		end

	// Pipeline still empty right after reset release
	// First fetched instruction reaches EXE only in the third cycle
	a_no_early_store: assert property (@(posedge CLK)
		$rose(rst_n) |-> !store_en ##1 !store_en)
		else begin
			$error("store reached data memory too soon after reset");
			fail_count++;
		end

endmodule

bind core core_properties i_core_properties (
	.CLK(CLK),
	.rst_n(rst_n),
	.imem_addr(imem_addr),
	.load_stall(load_stall),
	.store_en(id_exe.ctrl.dm_we)
);

//--- tests/core_tb.sv
`include "core_defines.svh"

module core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] OP_R = 7'b0110011, OP_I = 7'b0010011, OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_LW = 7'b0000011, OP_SW = 7'b0100011, OP_BR = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111, OP_JALR = 7'b1100111;
	localparam int DUMP = 256; // First word of the register dump

	logic              CLK = 1'b0;
	logic              rst_n;
	logic [`PC_W-1:0]  imem_addr;
	logic [31:0]       imem_data;
	logic [`BE_W-1:0]  con_write;
	logic [`DM_AW-1:0] con_addr;
	logic [`XLEN-1:0]  con_in;
	logic [`XLEN-1:0]  con_out;

	logic [31:0] prog [1024];      // Program ROM, zero is a bubble
	logic        landing [1024];   // Branch or jump target
	logic [31:0] dm_model [1024];
	logic [31:0] mreg [32];
	int          total, fin, n_pass, n_fail, errs;
	logic        model_ok, settled;
	logic [31:0] rd_val;

	core i_core (.*);

	always #10 CLK = ~CLK; // 20 ns period

	// Combinational ROM, same-cycle fetch
	assign imem_data = prog[imem_addr[`PC_W-1:2]];

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(input logic f7b, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, f7b, 5'b0, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] off, input logic [4:0] rs2);
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_SW}; // Base always x0
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [4:0] pick_rd();
		return 5'(1 + $urandom % 15);
	endfunction

	// Half the time the last result, for back-to-back dependencies
	function automatic logic [4:0] pick_src(input logic [4:0] last);
		return ($urandom % 2) ? last : pick_rd();
	endfunction

	// Forward target 1 to 4 slots ahead, never past the dump code
	function automatic int fwd_target(input int i, input int lo, input int tail);
		int t;
		t = i + lo + $urandom % 4;
		if (t > tail) t = tail;
		return t;
	endfunction

	task automatic build_program();
		int i, t, tail, kind;
		logic [4:0] last, rd, ra;
		logic [2:0] f3;
		for (int k = 0; k < 1024; k++) begin
			prog[k] = '0;
			landing[k] = 1'b0;
		end
		total = 60 + $urandom % 61;
		tail = total - 16;
		fin = total - 1;
		i = 0;
		last = 5'd1;
		while (i < tail) begin
			kind = $urandom % 10;
			rd = pick_rd();
			f3 = 3'($urandom);
			if (kind == 5 && i + 1 < tail) begin // Load, then use at once
				prog[i] = enc_i(12'(($urandom % 64) * 4), 5'd0, 3'b010, rd, OP_LW);
				prog[i+1] = enc_r(1'b0, pick_rd(), rd, 3'd0, pick_rd());
				last = prog[i+1][11:7];
				i += 2;
			end else if (kind == 9 && i + 1 < tail && !landing[i+1]) begin
				t = fwd_target(i, 2, tail);
				landing[t] = 1'b1;
				prog[i] = enc_i(12'(t * 4), 5'd0, 3'd0, 5'd15, OP_I); // x15 = target
				prog[i+1] = enc_i(12'd0, 5'd15, 3'd0, rd, OP_JALR);
				last = rd;
				i += 2;
			end else begin
				case (kind)
					4: prog[i] = {20'($urandom), rd, OP_LUI};
					6: prog[i] = enc_sw(12'(($urandom % 64) * 4), pick_src(last));
					7: begin
						t = fwd_target(i, 1, tail);
						landing[t] = 1'b1;
						if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0; // Reserved, use BEQ
						prog[i] = enc_b(13'((t - i) * 4), pick_src(last), pick_src(last), f3);
					end
					8: begin
						t = fwd_target(i, 1, tail);
						landing[t] = 1'b1;
						prog[i] = enc_j(21'((t - i) * 4), rd);
					end
					0, 1: prog[i] = enc_r((f3 == 0 || f3 == 5) && $urandom % 2,
						pick_src(last), pick_src(last), f3, rd);
					default: begin
						ra = pick_src(last);
						if (f3 == 3'd1) prog[i] = enc_i(12'($urandom % 32), ra, f3, rd, OP_I);
						else if (f3 == 3'd5) prog[i] = enc_i({1'b0, 1'($urandom), 5'b0,
							5'($urandom)}, ra, f3, rd, OP_I);
						else prog[i] = enc_i(12'($urandom), ra, f3, rd, OP_I);
					end
				endcase
				if (kind != 6 && kind != 7) last = rd;
				i += 1;
			end
		end
		for (int r = 1; r < 16; r++) prog[tail + r - 1] = enc_sw(12'((DUMP + r - 1) * 4), 5'(r));
		prog[fin] = enc_j(21'd0, 5'd0); // Spin on itself
	endtask

	// Reference ALU from the ISA definitions
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic run_model();
		logic [31:0] pc, npc, inst, a, b, imm_i, val, ea;
		logic        wen, tk;
		int          steps;
		pc = 0;
		steps = 0;
		for (int r = 0; r < 32; r++) mreg[r] = '0;
		while (pc != fin * 4 && steps < 4000) begin
			inst = prog[pc[11:2]];
			a = mreg[inst[19:15]];
			b = mreg[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			npc = pc + 4;
			wen = 1'b1;
			val = '0;
			case (inst[6:0])
				OP_R: val = alu_ref(inst[14:12], inst[30], a, b);
				OP_I: val = alu_ref(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, imm_i);
				OP_LUI: val = {inst[31:12], 12'b0};
				OP_LW: begin
					ea = a + imm_i;
					val = dm_model[ea[11:2]];
				end
				OP_SW: begin
					ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
					dm_model[ea[11:2]] = b;
					wen = 1'b0;
				end
				OP_BR: begin
					case (inst[14:12])
						3'd0: tk = (a == b);
						3'd1: tk = (a != b);
						3'd4: tk = ($signed(a) < $signed(b));
						3'd5: tk = ($signed(a) >= $signed(b));
						3'd6: tk = (a < b);
						default: tk = (a >= b);
					endcase
					if (tk) npc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
						inst[11:8], 1'b0};
					wen = 1'b0;
				end
				OP_JAL: begin
					val = pc + 4; // Link
					npc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				end
				default: begin // JALR
					val = pc + 4;
					npc = (a + imm_i) & ~32'd1;
				end
			endcase
			if (wen && inst[11:7] != 5'd0) mreg[inst[11:7]] = val;
			pc = npc;
			steps++;
		end
		model_ok = (pc == fin * 4);
	endtask

	// Con read data shows one cycle after the address
	task automatic read_con(input int addr, output logic [31:0] data);
		@(posedge CLK);
		con_addr <= `DM_AW'(addr);
		@(posedge CLK);
		@(negedge CLK);
		data = con_out;
	endtask

	task automatic compare(input string name, input int idx, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("mismatch %s word %0d: expected %h actual %h", name, idx, exp_v, act_v);
			errs++;
		end
	endtask

	task automatic report(input string name);
		if (errs == 0) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: failed with %0d errors", name, errs);
			n_fail++;
		end
		errs = 0;
	endtask

	// Fetch bounces between the spin JAL and the flushed slot after it
	task automatic wait_final_loop(output logic ok);
		int stable;
		stable = 0;
		ok = 1'b0;
		for (int cyc = 0; cyc < 5000 && !ok; cyc++) begin
			@(negedge CLK);
			if (imem_addr == `PC_W'(fin * 4) || imem_addr == `PC_W'(fin * 4 + 4)) stable++;
			else stable = 0;
			if (stable >= 8) ok = 1'b1;
		end
	endtask

	initial begin
		logic [31:0] d, m;
		logic [3:0]  mask;
		rst_n = 1'b0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		n_pass = 0;
		n_fail = 0;
		errs = 0;
		void'($urandom(58));
		build_program();
		// Full-word preload of every compared word, core held in reset
		for (int w = 0; w < DUMP + 15; w++) begin
			d = $urandom;
			dm_model[w] = d;
			@(posedge CLK);
			con_write <= '1;
			con_addr <= `DM_AW'(w);
			con_in <= d;
		end
		// Byte-masked merges over the load area
		for (int w = 0; w < 64; w++) begin
			d = $urandom;
			mask = 4'($urandom);
			m = dm_model[w];
			for (int b = 0; b < 4; b++) if (mask[b]) m[8*b +: 8] = d[8*b +: 8];
			dm_model[w] = m;
			@(posedge CLK);
			con_write <= mask;
			con_addr <= `DM_AW'(w);
			con_in <= d;
		end
		@(posedge CLK);
		con_write <= '0;
		for (int w = 0; w < 64; w++) begin
			read_con(w, rd_val);
			compare("con_port", w, dm_model[w], rd_val);
		end
		report("con_port");
		run_model();
		if (!model_ok) begin
			$display("model did not reach the final loop");
			errs++;
		end
		repeat (2) begin
			@(negedge CLK);
			compare("reset", 0, `RESET_PC, imem_addr);
		end
		@(posedge CLK);
		rst_n <= 1'b1;
		@(negedge CLK);
		compare("reset", 1, `RESET_PC, imem_addr);
		report("reset");
		wait_final_loop(settled);
		if (!settled) begin
			$display("timeout: fetch never settled on the final loop");
			$display("sim failed");
		end else begin
			for (int r = 1; r < 16; r++) begin
				read_con(DUMP + r - 1, rd_val);
				compare("reg_dump", r, mreg[r], rd_val);
			end
			report("reg_dump");
			for (int w = 0; w < DUMP + 15; w++) begin
				read_con(w, rd_val);
				compare("data_image", w, dm_model[w], rd_val);
			end
			report("data_image");
			if (i_core.i_core_properties.fail_count != 0) begin
				$display("%0d bound assertions failed during the run",
					i_core.i_core_properties.fail_count);
				errs++;
			end
			report("assertions");
			$display("tests: %0d passed, %0d failed", n_pass, n_fail);
			if (n_fail == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
		end
		$finish;
	end

endmodule
